//--- Bender.yml
package:
  name: sprite_engine

sources:
  - files:
      - source/sprite_pkg.sv
      - source/sprite_attr_if.sv
      - source/sprite_reg_file.sv
      - source/sprite_reg_decoder.sv
      - source/sprite_pixel_locator.sv
      - source/sprite_engine.sv
  - target: test
    files:
      - test/sprite_engine_sva.sv
      - test/tb_sprite_engine.sv

//--- files.f
source/sprite_pkg.sv
source/sprite_attr_if.sv
source/sprite_reg_file.sv
source/sprite_reg_decoder.sv
source/sprite_pixel_locator.sv
source/sprite_engine.sv
test/sprite_engine_sva.sv
test/tb_sprite_engine.sv

//--- source/sprite_attr_if.sv
interface sprite_attr_if import sprite_pkg::*; ();

  // Control flags from CTRL0.
  logic enabled;
  logic enable_scroll;
  logic enable_transp;
  logic enable_alpha;
  logic enable_color;
  logic flip_x;
  logic flip_y;
  logic flip_xy;
  logic [palette_width-1:0] palette;

  // Sprite size in pixels.
  logic [dim_width-1:0] width;
  logic [dim_width-1:0] height;

  // Start of texel data, already shifted if requested.
  logic [data_addr_width-1:0] data_offset;

  // Screen position and scroll offsets.
  logic [coord_width-1:0] ref_x;
  logic [coord_width-1:0] ref_y;
  logic [coord_width-1:0] offset_x;
  logic [coord_width-1:0] offset_y;

  logic [reg_data_width-1:0] color_key;

  modport decoder (
    output enabled, enable_scroll, enable_transp, enable_alpha, enable_color,
    output flip_x, flip_y, flip_xy, palette, width, height, data_offset,
    output ref_x, ref_y, offset_x, offset_y, color_key
  );

  modport locator (
    input enabled, enable_scroll, enable_transp, enable_alpha, enable_color,
    input flip_x, flip_y, flip_xy, palette, width, height, data_offset,
    input ref_x, ref_y, offset_x, offset_y, color_key
  );

endinterface

//--- source/sprite_engine.sv
module sprite_engine import sprite_pkg::*; #(
  parameter int NUM_SPRITES       = 4,
  parameter int DATA_OFFSET_SHIFT = 6
) (
  input  logic                       clk,
  input  logic                       rst_n,
  // Host register port.
  input  logic                       reg_wr,
  input  logic [sprite_id_width-1:0] reg_sprite,
  input  logic [reg_addr_width-1:0]  reg_addr,
  input  logic [reg_data_width-1:0]  reg_wdata,
  output logic [reg_data_width-1:0]  reg_rdata,
  // Pixel query port.
  input  logic                       px_req,
  input  logic [sprite_id_width-1:0] px_sprite,
  input  logic [coord_width-1:0]     px_x,
  input  logic [coord_width-1:0]     px_y,
  output logic                       px_valid,
  output logic                       px_hit,
  output logic [data_addr_width-1:0] px_addr,
  output logic [palette_width-1:0]   px_palette,
  output logic                       px_transp,
  output logic                       px_alpha,
  output logic                       px_color,
  output logic [reg_data_width-1:0]  px_color_key
);

  // Host words as union views.
  sprite_reg_word_t wdata_word;
  sprite_reg_word_t rdata_word;

  // Bank of the sprite under query.
  sprite_reg_word_t bank_regs [num_sprite_regs];

  sprite_attr_if u_attr_if ();

  assign wdata_word = sprite_reg_word_t'(reg_wdata);
  assign reg_rdata  = rdata_word.raw;

  // The query sprite picks the bank in the same cycle as px_req.
  sprite_reg_file #(
    .NUM_SPRITES (NUM_SPRITES)
  ) u_sprite_reg_file (
    .clk        (clk),
    .rst_n      (rst_n),
    .reg_wr     (reg_wr),
    .reg_sprite (reg_sprite),
    .reg_addr   (reg_addr),
    .reg_wdata  (wdata_word),
    .reg_rdata  (rdata_word),
    .sel_sprite (px_sprite),
    .sel_regs   (bank_regs)
  );

  sprite_reg_decoder #(
    .DATA_OFFSET_SHIFT (DATA_OFFSET_SHIFT)
  ) u_sprite_reg_decoder (
    .regs (bank_regs),
    .attr (u_attr_if.decoder)
  );

  sprite_pixel_locator u_sprite_pixel_locator (
    .clk          (clk),
    .rst_n        (rst_n),
    .px_req       (px_req),
    .px_x         (px_x),
    .px_y         (px_y),
    .attr         (u_attr_if.locator),
    .px_valid     (px_valid),
    .px_hit       (px_hit),
    .px_addr      (px_addr),
    .px_palette   (px_palette),
    .px_transp    (px_transp),
    .px_alpha     (px_alpha),
    .px_color     (px_color),
    .px_color_key (px_color_key)
  );

endmodule

//--- source/sprite_pixel_locator.sv
module sprite_pixel_locator import sprite_pkg::*; (
  input  logic                       clk,
  input  logic                       rst_n,
  // Query.
  input  logic                       px_req,
  input  logic [coord_width-1:0]     px_x,
  input  logic [coord_width-1:0]     px_y,
  sprite_attr_if.locator             attr,
  // Result, two cycles after px_req.
  output logic                       px_valid,
  output logic                       px_hit,
  output logic [data_addr_width-1:0] px_addr,
  output logic [palette_width-1:0]   px_palette,
  output logic                       px_transp,
  output logic                       px_alpha,
  output logic                       px_color,
  output logic [reg_data_width-1:0]  px_color_key
);

  // Stage one, combinational part.
  logic [coord_width-1:0] scroll_x;
  logic [coord_width-1:0] scroll_y;
  logic [coord_width-1:0] loc_x;
  logic [coord_width-1:0] loc_y;
  logic                   in_bounds;

  // Stage one registers.
  logic                       s1_valid;
  logic                       s1_hit;
  logic [coord_width-1:0]     s1_lx;
  logic [coord_width-1:0]     s1_ly;
  logic [dim_width-1:0]       s1_width;
  logic [dim_width-1:0]       s1_height;
  logic                       s1_flip_x;
  logic                       s1_flip_y;
  logic                       s1_flip_xy;
  logic [data_addr_width-1:0] s1_data_offset;
  logic [palette_width-1:0]   s1_palette;
  logic                       s1_transp;
  logic                       s1_alpha;
  logic                       s1_color;
  logic [reg_data_width-1:0]  s1_color_key;

  // Stage two, combinational part.
  logic [coord_width-1:0]     flip_lx;
  logic [coord_width-1:0]     flip_ly;
  logic [coord_width-1:0]     tex_x;
  logic [coord_width-1:0]     tex_y;
  logic [dim_width-1:0]       pitch;
  logic [data_addr_width-1:0] next_addr;

  // Scroll, then move into sprite-local space.
  // All coordinate math wraps at 256.
  always_comb begin
    scroll_x  = attr.enable_scroll ? px_x + attr.offset_x : px_x;
    scroll_y  = attr.enable_scroll ? px_y + attr.offset_y : px_y;
    loc_x     = scroll_x - attr.ref_x;
    loc_y     = scroll_y - attr.ref_y;
    // Wrapped negatives land high and fall outside.
    in_bounds = attr.enabled &&
                (loc_x < coord_width'(attr.width)) &&
                (loc_y < coord_width'(attr.height));
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      s1_valid <= 1'b0;
      s1_hit   <= 1'b0;
    end else begin
      s1_valid <= px_req;
      s1_hit   <= px_req && in_bounds;
    end
  end

  // Attributes are sampled in the request cycle.
  always_ff @(posedge clk) begin
    if (px_req) begin
      s1_lx          <= loc_x;
      s1_ly          <= loc_y;
      s1_width       <= attr.width;
      s1_height      <= attr.height;
      s1_flip_x      <= attr.flip_x;
      s1_flip_y      <= attr.flip_y;
      s1_flip_xy     <= attr.flip_xy;
      s1_data_offset <= attr.data_offset;
      s1_palette     <= attr.palette;
      s1_transp      <= attr.enable_transp;
      s1_alpha       <= attr.enable_alpha;
      s1_color       <= attr.enable_color;
      s1_color_key   <= attr.color_key;
    end
  end

  // Mirror within the sprite box.
  // Out-of-box coordinates still produce an address.
  always_comb begin
    flip_lx = s1_flip_x ? coord_width'(s1_width) - coord_width'(1) - s1_lx : s1_lx;
    flip_ly = s1_flip_y ? coord_width'(s1_height) - coord_width'(1) - s1_ly : s1_ly;
    // Diagonal flip transposes the texture so rows are height long.
    if (s1_flip_xy) begin
      tex_x = flip_ly;
      tex_y = flip_lx;
      pitch = s1_height;
    end else begin
      tex_x = flip_lx;
      tex_y = flip_ly;
      pitch = s1_width;
    end
    next_addr = s1_data_offset +
                data_addr_width'(tex_y) * data_addr_width'(pitch) +
                data_addr_width'(tex_x);
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      px_valid <= 1'b0;
      px_hit   <= 1'b0;
    end else begin
      px_valid <= s1_valid;
      px_hit   <= s1_valid && s1_hit;
    end
  end

  // Result payload holds its value between queries.
  always_ff @(posedge clk) begin
    if (s1_valid) begin
      px_addr      <= next_addr;
      px_palette   <= s1_palette;
      px_transp    <= s1_transp;
      px_alpha     <= s1_alpha;
      px_color     <= s1_color;
      px_color_key <= s1_color_key;
    end
  end

endmodule

//--- source/sprite_pkg.sv
package sprite_pkg;

  // Register word and bank geometry.
  localparam int reg_data_width = 16;
  localparam int num_sprite_regs = 8;
  localparam int reg_addr_width = $clog2(num_sprite_regs);

  // Sprite number width on the host and query ports.
  localparam int sprite_id_width = 2;

  // Register indices within one sprite bank.
  // Index 7 is reserved and only stored.
  localparam int sprite_ctrl0 = 0;
  localparam int sprite_ctrl1 = 1;
  localparam int sprite_data_offset = 2;
  localparam int sprite_ref_xy = 3;
  localparam int sprite_color_key = 4;
  localparam int sprite_offset_x = 5;
  localparam int sprite_offset_y = 6;

  // VRAM addresses carry one extra bit above the word address.
  localparam int vram_addr_width = 16;
  localparam int data_addr_width = vram_addr_width + 1;

  // Screen and sprite-local coordinates.
  localparam int coord_width = 8;

  // Dimensions are sprite_min_size shifted by a 2-bit size code.
  localparam int sprite_min_size = 8;
  localparam int size_field_width = 2;
  localparam int dim_width = 7;

  localparam int palette_width = 4;

  // CTRL0 layout with the MSB first.
  // Bit 0 is enabled, bit 8 is shift_data_offset.
  typedef struct packed {
    logic [palette_width-1:0] palette;
    logic [2:0]               reserved;
    logic                     shift_data_offset;
    logic                     flip_xy;
    logic                     flip_y;
    logic                     flip_x;
    logic                     enable_color;
    logic                     enable_alpha;
    logic                     enable_transp;
    logic                     enable_scroll;
    logic                     enabled;
  } sprite_ctrl0_t;

  // CTRL1 layout holds only the two size codes.
  typedef struct packed {
    logic [reg_data_width-2*size_field_width-1:0] reserved;
    logic [size_field_width-1:0]                  vsize;
    logic [size_field_width-1:0]                  hsize;
  } sprite_ctrl1_t;

  // One register word, seen raw or through either control layout.
  typedef union packed {
    logic [reg_data_width-1:0] raw;
    sprite_ctrl0_t             ctrl0;
    sprite_ctrl1_t             ctrl1;
  } sprite_reg_word_t;

  // Size code to pixel count of 8, 16, 32 or 64.
  function automatic logic [dim_width-1:0] sprite_dim(
    input logic [size_field_width-1:0] size
  );
    return dim_width'(sprite_min_size << size);
  endfunction

endpackage

//--- source/sprite_reg_decoder.sv
module sprite_reg_decoder import sprite_pkg::*; #(
  parameter int DATA_OFFSET_SHIFT = 6
) (
  input sprite_reg_word_t regs [num_sprite_regs],
  sprite_attr_if.decoder  attr
);

  // Control registers seen through their own layouts.
  sprite_ctrl0_t ctrl0;
  sprite_ctrl1_t ctrl1;

  // Data offset before the optional shift.
  logic [data_addr_width-1:0] raw_offset;

  // Remaining whole registers.
  logic [reg_data_width-1:0] ref_xy;
  logic [reg_data_width-1:0] offset_x_word;
  logic [reg_data_width-1:0] offset_y_word;

  assign ctrl0 = regs[sprite_ctrl0].ctrl0;
  assign ctrl1 = regs[sprite_ctrl1].ctrl1;

  assign ref_xy        = regs[sprite_ref_xy].raw;
  assign offset_x_word = regs[sprite_offset_x].raw;
  assign offset_y_word = regs[sprite_offset_y].raw;

  // CTRL0 flags.
  assign attr.enabled       = ctrl0.enabled;
  assign attr.enable_scroll = ctrl0.enable_scroll;
  assign attr.enable_transp = ctrl0.enable_transp;
  assign attr.enable_alpha  = ctrl0.enable_alpha;
  assign attr.enable_color  = ctrl0.enable_color;
  assign attr.flip_x        = ctrl0.flip_x;
  assign attr.flip_y        = ctrl0.flip_y;
  assign attr.flip_xy       = ctrl0.flip_xy;
  assign attr.palette       = ctrl0.palette;

  // Size codes become pixel counts.
  assign attr.width  = sprite_dim(ctrl1.hsize);
  assign attr.height = sprite_dim(ctrl1.vsize);

  // The offset register holds 16 bits, the address space 17.
  assign raw_offset = data_addr_width'(regs[sprite_data_offset].raw);

  // Shifted offsets address coarse blocks of VRAM.
  // Bits shifted past bit 16 are lost.
  assign attr.data_offset = ctrl0.shift_data_offset ?
                            (raw_offset << DATA_OFFSET_SHIFT) : raw_offset;

  // Reference point, x in the low byte, y in the high byte.
  assign attr.ref_x = ref_xy[coord_width-1:0];
  assign attr.ref_y = ref_xy[2*coord_width-1:coord_width];

  // Scroll offsets use the low byte only.
  assign attr.offset_x = offset_x_word[coord_width-1:0];
  assign attr.offset_y = offset_y_word[coord_width-1:0];

  assign attr.color_key = regs[sprite_color_key].raw;

endmodule

//--- source/sprite_reg_file.sv
module sprite_reg_file import sprite_pkg::*; #(
  parameter int NUM_SPRITES = 4
) (
  input  logic                       clk,
  input  logic                       rst_n,
  // Host write and read port.
  input  logic                       reg_wr,
  input  logic [sprite_id_width-1:0] reg_sprite,
  input  logic [reg_addr_width-1:0]  reg_addr,
  input  sprite_reg_word_t           reg_wdata,
  output sprite_reg_word_t           reg_rdata,
  // Bank read port for the query path.
  input  logic [sprite_id_width-1:0] sel_sprite,
  output sprite_reg_word_t           sel_regs [num_sprite_regs]
);

  // All sprite banks.
  sprite_reg_word_t regs_q [NUM_SPRITES][num_sprite_regs];

  // Sprite numbers beyond NUM_SPRITES address nothing.
  logic host_in_range;
  logic sel_in_range;

  assign host_in_range = (int'(reg_sprite) < NUM_SPRITES);
  assign sel_in_range  = (int'(sel_sprite) < NUM_SPRITES);

  // Registers come up as zero so every sprite starts disabled.
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      for (int s = 0; s < NUM_SPRITES; s++) begin
        for (int r = 0; r < num_sprite_regs; r++) begin
          regs_q[s][r] <= '0;
        end
      end
    end else if (reg_wr && host_in_range) begin
      // One word per strobe, visible on the read port next cycle.
      regs_q[reg_sprite][reg_addr] <= reg_wdata;
    end
  end

  // Host read-back is combinational.
  always_comb begin
    reg_rdata = '0;
    if (host_in_range) begin
      reg_rdata = regs_q[reg_sprite][reg_addr];
    end
  end

  // Whole bank of the queried sprite.
  // Out-of-range sprites read as all zero and so stay disabled.
  always_comb begin
    for (int r = 0; r < num_sprite_regs; r++) begin
      sel_regs[r] = '0;
      if (sel_in_range) begin
        sel_regs[r] = regs_q[sel_sprite][r];
      end
    end
  end

endmodule

//--- test/sprite_engine_sva.sv
module sprite_engine_sva (
  input logic clk,
  input logic rst_n,
  input logic px_req,
  input logic px_valid,
  input logic px_hit
);

  // Count of failed assertions.
  int fail_count = 0;

  // No result may leave the locator while it is held in reset.
  assert property (@(posedge clk) !rst_n |-> !px_valid)
    else begin
      fail_count++;
      $error("px_valid set during reset");
    end

  // Every request returns exactly two cycles later.
  assert property (@(posedge clk) disable iff (!rst_n) px_req |-> ##2 px_valid)
    else begin
      fail_count++;
      $error("px_valid missing two cycles after px_req");
    end

  // And no result appears without its request.
  assert property (@(posedge clk) disable iff (!rst_n) px_valid |-> $past(px_req, 2))
    else begin
      fail_count++;
      $error("px_valid without px_req two cycles earlier");
    end

  // A hit only comes with a valid result.
  assert property (@(posedge clk) disable iff (!rst_n) px_hit |-> px_valid)
    else begin
      fail_count++;
      $error("px_hit set while px_valid is low");
    end

endmodule

bind sprite_pixel_locator sprite_engine_sva u_locator_sva (
  .clk      (clk),
  .rst_n    (rst_n),
  .px_req   (px_req),
  .px_valid (px_valid),
  .px_hit   (px_hit)
);

//--- test/tb_sprite_engine.sv
module tb_sprite_engine;

  localparam int num_sprites = 4;
  localparam int offset_shift = 6;
  localparam int period = 4;

  // Cycles per test. Reads take one, writes two and their checks one, flushes three.
  localparam int test1_ops = 8 + 32 * 2 + 32 * 3;
  localparam int test2_ops = 32 * (7 * 2 + 16 + 3);
  localparam int test3_ops = 8 * (7 * 2 + 16 + 3);
  localparam int test4_ops = 4 * (7 * 2 + 16 + 3);
  localparam int test5_ops = 4 * 7 * 2 + 32 + 3;
  localparam int total_ops = test1_ops + test2_ops + test3_ops + test4_ops + test5_ops;
  localparam int timeout = total_ops * period + 1000;

  // Expected result of one pixel query.
  typedef struct packed {
    logic        hit;
    logic [16:0] addr;
    logic [3:0]  palette;
    logic        transp;
    logic        alpha;
    logic        color;
    logic [15:0] key;
  } expect_t;

  logic        clk;
  logic        rst_n;
  logic        reg_wr;
  logic [1:0]  reg_sprite;
  logic [2:0]  reg_addr;
  logic [15:0] reg_wdata;
  logic [15:0] reg_rdata;
  logic        px_req;
  logic [1:0]  px_sprite;
  logic [7:0]  px_x;
  logic [7:0]  px_y;
  logic        px_valid;
  logic        px_hit;
  logic [16:0] px_addr;
  logic [3:0]  px_palette;
  logic        px_transp;
  logic        px_alpha;
  logic        px_color;
  logic [15:0] px_color_key;

  // Shadow of every register, and results still in flight.
  logic [15:0] shadow [num_sprites][8];
  expect_t     exp_q [$];
  int          checks = 0;
  int          errors = 0;
  int          test_errors = 0;

  sprite_engine #(
    .NUM_SPRITES       (num_sprites),
    .DATA_OFFSET_SHIFT (offset_shift)
  ) u_sprite_engine (
    .clk          (clk),
    .rst_n        (rst_n),
    .reg_wr       (reg_wr),
    .reg_sprite   (reg_sprite),
    .reg_addr     (reg_addr),
    .reg_wdata    (reg_wdata),
    .reg_rdata    (reg_rdata),
    .px_req       (px_req),
    .px_sprite    (px_sprite),
    .px_x         (px_x),
    .px_y         (px_y),
    .px_valid     (px_valid),
    .px_hit       (px_hit),
    .px_addr      (px_addr),
    .px_palette   (px_palette),
    .px_transp    (px_transp),
    .px_alpha     (px_alpha),
    .px_color     (px_color),
    .px_color_key (px_color_key)
  );

  initial begin
    clk = 1'b0;
    forever #(period / 2) clk = ~clk;
  end

  // Stops a run whose responses never arrive.
  initial begin
    #(timeout);
    $display("Timeout: the tests did not finish within %0d time units", timeout);
    $display("sim failed");
    $finish;
  end

  // Locator rule applied to the shadow registers.
  function automatic expect_t ref_query(input int s, input logic [7:0] x, input logic [7:0] y);
    logic [15:0] c0;
    logic [15:0] c1;
    logic [7:0]  sx;
    logic [7:0]  sy;
    logic [7:0]  lx;
    logic [7:0]  ly;
    logic [7:0]  w;
    logic [7:0]  h;
    logic [7:0]  t;
    logic [16:0] off;
    expect_t     e;
    c0 = shadow[s][0];
    c1 = shadow[s][1];
    w = 8'(8 << c1[1:0]);
    h = 8'(8 << c1[3:2]);
    sx = c0[1] ? x + shadow[s][5][7:0] : x;
    sy = c0[1] ? y + shadow[s][6][7:0] : y;
    lx = sx - shadow[s][3][7:0];
    ly = sy - shadow[s][3][15:8];
    e.hit = c0[0] && (lx < w) && (ly < h);
    if (c0[5]) lx = w - 8'd1 - lx;
    if (c0[6]) ly = h - 8'd1 - ly;
    off = 17'(shadow[s][2]);
    if (c0[8]) off = off << offset_shift;
    if (c0[7]) begin
      t = lx;
      lx = ly;
      ly = t;
      e.addr = off + 17'(ly) * 17'(h) + 17'(lx);
    end else begin
      e.addr = off + 17'(ly) * 17'(w) + 17'(lx);
    end
    e.palette = c0[15:12];
    e.transp = c0[2];
    e.alpha = c0[3];
    e.color = c0[4];
    e.key = shadow[s][4];
    return e;
  endfunction

  // Local coordinate just outside, on, or past the box edge.
  function automatic logic [7:0] edge_point(input logic [7:0] dim, input int k);
    case (k)
      0: return 8'hff;
      1: return 8'd0;
      2: return dim - 8'd1;
      default: return dim;
    endcase
  endfunction

  task automatic write_reg(input logic [1:0] s, input logic [2:0] a, input logic [15:0] d);
    @(posedge clk);
    px_req     <= 1'b0;
    reg_wr     <= 1'b1;
    reg_sprite <= s;
    reg_addr   <= a;
    reg_wdata  <= d;
    shadow[s][a] = d;
    @(posedge clk);
    reg_wr <= 1'b0;
  endtask

  task automatic check_rdata(input logic [1:0] s, input logic [2:0] a, input logic [15:0] d);
    @(negedge clk);
    checks++;
    assert (reg_rdata == d) else begin
      errors++;
      $display("[ERROR] %0t: sprite %0d register %0d reads %h, expected %h",
               $time, s, a, reg_rdata, d);
    end
  endtask

  task automatic read_check(input logic [1:0] s, input logic [2:0] a, input logic [15:0] d);
    @(posedge clk);
    reg_sprite <= s;
    reg_addr   <= a;
    check_rdata(s, a, d);
  endtask

  // Registers 0 to 6 of one sprite; index 7 is left alone.
  task automatic setup_sprite(input logic [1:0] s, input logic [15:0] c0, input logic [15:0] c1,
                              input logic [15:0] off, input logic [15:0] rxy,
                              input logic [15:0] ox, input logic [15:0] oy,
                              input logic [15:0] key);
    write_reg(s, 3'd0, c0);
    write_reg(s, 3'd1, c1);
    write_reg(s, 3'd2, off);
    write_reg(s, 3'd3, rxy);
    write_reg(s, 3'd4, key);
    write_reg(s, 3'd5, ox);
    write_reg(s, 3'd6, oy);
  endtask

  task automatic query(input logic [1:0] s, input logic [7:0] x, input logic [7:0] y);
    @(posedge clk);
    px_req    <= 1'b1;
    px_sprite <= s;
    px_x      <= x;
    px_y      <= y;
    exp_q.push_back(ref_query(s, x, y));
  endtask

  // Ends a burst of queries and waits for all of them to return.
  task automatic flush();
    @(posedge clk);
    px_req <= 1'b0;
    wait (exp_q.size() == 0);
  endtask

  task automatic report_test(input string name);
    $display("%s: %0d errors", name, errors - test_errors);
    test_errors = errors;
  endtask

  // Results are checked in the middle of the cycle, in request order.
  always @(negedge clk) begin
    expect_t e;
    if (rst_n && px_valid) begin
      if (exp_q.size() == 0) begin
        errors++;
        $display("A result arrived at time %0t with no query outstanding", $time);
      end else begin
        e = exp_q.pop_front();
        checks++;
        assert (px_hit == e.hit && px_addr == e.addr) else begin
          errors++;
          $display("[ERROR] %0t: hit %0b addr %h, expected hit %0b addr %h",
                   $time, px_hit, px_addr, e.hit, e.addr);
        end
        assert ({px_palette, px_transp, px_alpha, px_color, px_color_key} ==
                {e.palette, e.transp, e.alpha, e.color, e.key}) else begin
          errors++;
          $display("[ERROR] %0t: attributes %h %b%b%b %h, expected %h %b%b%b %h",
                   $time, px_palette, px_transp, px_alpha, px_color, px_color_key,
                   e.palette, e.transp, e.alpha, e.color, e.key);
        end
      end
    end
  end

  initial begin
    logic [15:0] rxy;
    logic [15:0] ox;
    logic [15:0] oy;
    logic [15:0] d;
    logic [7:0]  w;
    logic [7:0]  h;
    void'($urandom(32'h7c4c));
    rst_n = 1'b0;
    reg_wr = 1'b0;
    reg_sprite = '0;
    reg_addr = '0;
    reg_wdata = '0;
    px_req = 1'b0;
    px_sprite = '0;
    px_x = '0;
    px_y = '0;
    for (int s = 0; s < num_sprites; s++)
      for (int r = 0; r < 8; r++)
        shadow[s][r] = '0;
    repeat (10) @(posedge clk);
    rst_n <= 1'b1;

    // Quiet outputs after reset, zeroed banks, then read-back of random words.
    repeat (8) begin
      @(negedge clk);
      checks++;
      assert (!px_valid && !px_hit) else begin
        errors++;
        $display("[ERROR] %0t: px_valid or px_hit set with no query", $time);
      end
    end
    for (int s = 0; s < num_sprites; s++)
      for (int r = 0; r < 8; r++)
        read_check(s, r, 16'h0);
    for (int s = 0; s < num_sprites; s++) begin
      for (int r = 0; r < 8; r++) begin
        d = 16'($urandom);
        write_reg(s, r, d);
        check_rdata(s, r, d);
      end
    end
    // Every word once more so a write that landed in another bank shows up.
    for (int s = 0; s < num_sprites; s++)
      for (int r = 0; r < 8; r++)
        read_check(s, r, shadow[s][r]);
    report_test("test 1 reset and read-back");

    // Every size code, probed around all four box edges.
    for (int en = 0; en < 2; en++) begin
      for (int hs = 0; hs < 4; hs++) begin
        for (int vs = 0; vs < 4; vs++) begin
          rxy = 16'($urandom);
          setup_sprite(0, 16'(en), 16'(vs * 4 + hs), 16'($urandom), rxy, 16'h0, 16'h0,
                       16'($urandom));
          w = 8'(8 << hs);
          h = 8'(8 << vs);
          for (int i = 0; i < 16; i++)
            query(0, rxy[7:0] + edge_point(w, i % 4), rxy[15:8] + edge_point(h, i / 4));
          flush();
        end
      end
    end
    report_test("test 2 dimensions and bounds");

    // All flip combinations on a 16 by 32 sprite.
    for (int f = 0; f < 8; f++) begin
      rxy = 16'($urandom);
      setup_sprite(1, 16'(1 | (f << 5)), 16'h0009, 16'($urandom), rxy, 16'h0, 16'h0,
                   16'($urandom));
      for (int i = 0; i < 16; i++)
        query(1, rxy[7:0] + 8'($urandom % 16), rxy[15:8] + 8'($urandom % 32));
      flush();
    end
    report_test("test 3 flips and swap");

    // Sprite near the screen corner so boxes wrap past 255.
    for (int sc = 0; sc < 2; sc++) begin
      for (int sh = 0; sh < 2; sh++) begin
        rxy = {8'(240 + $urandom % 16), 8'(240 + $urandom % 16)};
        ox = 16'($urandom);
        oy = 16'($urandom);
        setup_sprite(2, 16'(1 | (sc << 1) | (sh << 8)), 16'h0005, 16'($urandom), rxy, ox, oy,
                     16'($urandom));
        for (int i = 0; i < 16; i++)
          query(2, rxy[7:0] - (sc != 0 ? ox[7:0] : 8'd0) + 8'($urandom % 24) - 8'd2,
                rxy[15:8] - (sc != 0 ? oy[7:0] : 8'd0) + 8'($urandom % 24) - 8'd2);
        flush();
      end
    end
    report_test("test 4 scroll and data offset");

    // Back-to-back queries that rotate through all sprites.
    for (int s = 0; s < num_sprites; s++)
      setup_sprite(s, 16'($urandom) | 16'h1, 16'($urandom), 16'($urandom), 16'($urandom),
                   16'($urandom), 16'($urandom), 16'($urandom));
    for (int i = 0; i < 32; i++)
      query(2'(i % 4), 8'($urandom), 8'($urandom));
    flush();
    report_test("test 5 pipelining and pass-through");

    errors += u_sprite_engine.u_sprite_pixel_locator.u_locator_sva.fail_count;
    $display("checks: %0d, errors: %0d", checks, errors);
    if (errors == 0) begin
      $display("sim passed");
    end else begin
      $display("sim failed");
    end
    $finish;
  end

endmodule
